/* design/attn_scorer.sv */
`timescale 1ns/1ps
`default_nettype none

module attn_scorer (
  input  wire                                                clk,
  input  wire                                                rst_n,
  input  wire [gat_pkg::NUM_FEAT_OUT-1:0][gat_pkg::WH_W-1:0] wh_i,
  input  wire [gat_pkg::TAG_W-1:0]                           tag_i,
  input  wire                                                valid_i,
  input  wire gat_pkg::attn_wr_t                             attn_wr_i,
  input  wire                                                out_ready_i,
  output logic                                               out_valid_o,
  output gat_pkg::node_out_t                                 out_node_o,
  output logic                                               advance_o
);
  import gat_pkg::*;

  logic [A_LEN-1:0][DATA_W-1:0] a_vec;
  logic signed [SCORE_W-1:0]    score_src;
  logic signed [SCORE_W-1:0]    score_dst;
  logic                         out_valid_q;
  node_out_t                    out_node_q;

  // Attention vector, source half then destination half
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      a_vec <= '0;
    end else if (attn_wr_i.en) begin
      a_vec[attn_wr_i.idx] <= attn_wr_i.data;
    end
  end

  always_comb begin
    score_src = '0;
    score_dst = '0;
    for (int k = 0; k < NUM_FEAT_OUT; k++) begin
      score_src = score_src + $signed(a_vec[k]) * $signed(wh_i[k]);
      score_dst = score_dst + $signed(a_vec[NUM_FEAT_OUT + k]) * $signed(wh_i[k]);
    end
  end

  // Output slot free or being drained this cycle
  assign advance_o = !out_valid_q || out_ready_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid_q <= 1'b0;
    end else if (advance_o) begin
      out_valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (advance_o && valid_i) begin
      out_node_q.tag       <= tag_i;
      out_node_q.wh        <= wh_i;
      out_node_q.score_src <= score_src;
      out_node_q.score_dst <= score_dst;
    end
  end

  assign out_valid_o = out_valid_q;
  assign out_node_o  = out_node_q;

endmodule

`default_nettype wire

/* design/gat_pkg.sv */
`default_nettype none

package gat_pkg;

  // Layer sizes
  localparam int NUM_FEAT_IN  = 4;
  localparam int NUM_FEAT_OUT = 4;
  localparam int DATA_W       = 8;
  localparam int WH_W         = 18;
  localparam int SCORE_W      = 28;
  localparam int TAG_W        = 12;

  // Configuration address map, weights first then attention vector
  localparam int CFG_ADDR_W = 5;
  localparam int A_BASE     = 16;
  localparam int A_LEN      = 2 * NUM_FEAT_OUT;

  localparam int ROW_W   = $clog2(NUM_FEAT_IN);
  localparam int COL_W   = $clog2(NUM_FEAT_OUT);
  localparam int A_IDX_W = $clog2(A_LEN);

  typedef enum logic [1:0] {
    CFG_WEIGHT,
    CFG_ATTN,
    CFG_NONE
  } cfg_op_e;

  typedef struct packed {
    logic [TAG_W-1:0]                    tag;
    logic [NUM_FEAT_IN-1:0][DATA_W-1:0]  feat;
  } node_in_t;

  typedef struct packed {
    logic [CFG_ADDR_W-1:0] addr;
    logic [DATA_W-1:0]     data;
  } cfg_wr_t;

  typedef struct packed {
    logic              we;
    logic [ROW_W-1:0]  row;
    logic [DATA_W-1:0] data;
  } lane_wr_t;

  typedef struct packed {
    logic               en;
    logic [A_IDX_W-1:0] idx;
    logic [DATA_W-1:0]  data;
  } attn_wr_t;

  typedef struct packed {
    logic [TAG_W-1:0]                    tag;
    logic [NUM_FEAT_OUT-1:0][WH_W-1:0]   wh;
    logic [SCORE_W-1:0]                  score_src;
    logic [SCORE_W-1:0]                  score_dst;
  } node_out_t;

endpackage

`default_nettype wire

/* design/gat_proj_top.sv */
`timescale 1ns/1ps
`default_nettype none

module gat_proj_top (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     in_valid_i,
  output logic                    in_ready_o,
  input  wire gat_pkg::node_in_t  in_node_i,
  output logic                    out_valid_o,
  input  wire                     out_ready_i,
  output gat_pkg::node_out_t      out_node_o,
  input  wire                     cfg_we_i,
  input  wire gat_pkg::cfg_wr_t   cfg_i
);
  import gat_pkg::*;

  logic                              advance;
  node_in_t                          node;
  logic                              node_valid;
  lane_wr_t [NUM_FEAT_OUT-1:0]       lane_wr;
  attn_wr_t                          attn_wr;
  logic [TAG_W-1:0]                  lane_tag;
  logic                              lane_tag_valid;
  logic [NUM_FEAT_OUT-1:0][WH_W-1:0] wh;

  node_dispatcher u_dispatcher (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_valid_i   (in_valid_i),
    .in_node_i    (in_node_i),
    .in_ready_o   (in_ready_o),
    .advance_i    (advance),
    .cfg_we_i     (cfg_we_i),
    .cfg_i        (cfg_i),
    .node_o       (node),
    .node_valid_o (node_valid),
    .lane_wr_o    (lane_wr),
    .attn_wr_o    (attn_wr),
    .tag_o        (lane_tag),
    .tag_valid_o  (lane_tag_valid)
  );

  // One lane per output feature
  for (genvar k = 0; k < NUM_FEAT_OUT; k++) begin : u_lane
    wh_lane u_wh_lane (
      .clk       (clk),
      .rst_n     (rst_n),
      .advance_i (advance),
      .node_i    (node),
      .valid_i   (node_valid),
      .wr_i      (lane_wr[k]),
      .wh_o      (wh[k])
    );
  end

  attn_scorer u_scorer (
    .clk         (clk),
    .rst_n       (rst_n),
    .wh_i        (wh),
    .tag_i       (lane_tag),
    .valid_i     (lane_tag_valid),
    .attn_wr_i   (attn_wr),
    .out_ready_i (out_ready_i),
    .out_valid_o (out_valid_o),
    .out_node_o  (out_node_o),
    .advance_o   (advance)
  );

endmodule

`default_nettype wire

/* design/node_dispatcher.sv */
`timescale 1ns/1ps
`default_nettype none

module node_dispatcher (
  input  wire                                           clk,
  input  wire                                           rst_n,
  input  wire                                           in_valid_i,
  input  wire gat_pkg::node_in_t                        in_node_i,
  output logic                                          in_ready_o,
  input  wire                                           advance_i,
  input  wire                                           cfg_we_i,
  input  wire gat_pkg::cfg_wr_t                         cfg_i,
  output gat_pkg::node_in_t                             node_o,
  output logic                                          node_valid_o,
  output gat_pkg::lane_wr_t [gat_pkg::NUM_FEAT_OUT-1:0] lane_wr_o,
  output gat_pkg::attn_wr_t                             attn_wr_o,
  output logic [gat_pkg::TAG_W-1:0]                     tag_o,
  output logic                                          tag_valid_o
);
  import gat_pkg::*;

  cfg_op_e          cfg_op;
  logic [ROW_W-1:0] cfg_row;
  logic [COL_W-1:0] cfg_col;
  node_in_t         node_q;
  logic             node_valid_q;
  logic [TAG_W-1:0] tag_q;
  logic             tag_valid_q;

  // Whole pipeline moves together
  assign in_ready_o = advance_i;

  always_comb begin
    if (!cfg_we_i) begin
      cfg_op = CFG_NONE;
    end else if (cfg_i.addr < CFG_ADDR_W'(A_BASE)) begin
      cfg_op = CFG_WEIGHT;
    end else if (cfg_i.addr < CFG_ADDR_W'(A_BASE + A_LEN)) begin
      cfg_op = CFG_ATTN;
    end else begin
      cfg_op = CFG_NONE;
    end
  end

  // Weight address is row * NUM_FEAT_OUT + column
  assign cfg_row = ROW_W'(cfg_i.addr / NUM_FEAT_OUT);
  assign cfg_col = COL_W'(cfg_i.addr % NUM_FEAT_OUT);

  always_comb begin
    for (int k = 0; k < NUM_FEAT_OUT; k++) begin
      lane_wr_o[k].we   = (cfg_op == CFG_WEIGHT) && (cfg_col == COL_W'(k));
      lane_wr_o[k].row  = cfg_row;
      lane_wr_o[k].data = cfg_i.data;
    end
    attn_wr_o.en   = (cfg_op == CFG_ATTN);
    attn_wr_o.idx  = A_IDX_W'(cfg_i.addr - CFG_ADDR_W'(A_BASE));
    attn_wr_o.data = cfg_i.data;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      node_valid_q <= 1'b0;
      tag_valid_q  <= 1'b0;
    end else if (advance_i) begin
      node_valid_q <= in_valid_i;
      tag_valid_q  <= node_valid_q;
    end
  end

  // Tag copy lines up with the lane result register
  always_ff @(posedge clk) begin
    if (advance_i && in_valid_i) begin
      node_q <= in_node_i;
    end
    if (advance_i && node_valid_q) begin
      tag_q <= node_q.tag;
    end
  end

  assign node_o       = node_q;
  assign node_valid_o = node_valid_q;
  assign tag_o        = tag_q;
  assign tag_valid_o  = tag_valid_q;

endmodule

`default_nettype wire

/* design/wh_lane.sv */
`timescale 1ns/1ps
`default_nettype none

module wh_lane (
  input  wire                               clk,
  input  wire                               rst_n,
  input  wire                               advance_i,
  input  wire gat_pkg::node_in_t            node_i,
  input  wire                               valid_i,
  input  wire gat_pkg::lane_wr_t            wr_i,
  output logic signed [gat_pkg::WH_W-1:0]   wh_o
);
  import gat_pkg::*;

  logic [NUM_FEAT_IN-1:0][DATA_W-1:0] w_col;
  logic signed [WH_W-1:0]             mac;
  logic signed [WH_W-1:0]             wh_q;

  // One column of W, one entry per input feature
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      w_col <= '0;
    end else if (wr_i.we) begin
      w_col[wr_i.row] <= wr_i.data;
    end
  end

  // Full width signed sum, cannot overflow
  always_comb begin
    mac = '0;
    for (int i = 0; i < NUM_FEAT_IN; i++) begin
      mac = mac + $signed(node_i.feat[i]) * $signed(w_col[i]);
    end
  end

  always_ff @(posedge clk) begin
    if (advance_i && valid_i) begin
      wh_q <= mac;
    end
  end

  assign wh_o = wh_q;

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator, result taken from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/1ps --top-module tb_gat_proj \
  -f src.f -o sim_gat_proj \
  && ./obj_dir/sim_gat_proj > sim.log 2>&1
cat sim.log 2>/dev/null

grep -q "^Simulation finished: PASS$" sim.log && echo "run passed" \
  || { echo "run failed"; exit 1; }

/* src.f */
+incdir+verification
design/gat_pkg.sv
design/node_dispatcher.sv
design/wh_lane.sv
design/attn_scorer.sv
design/gat_proj_top.sv
verification/tb_gat_proj.sv

/* verification/gat_model.svh */
`ifndef GAT_MODEL_SVH
`define GAT_MODEL_SVH

// Model copies of W and a as signed integers
int w_model [NUM_FEAT_IN][NUM_FEAT_OUT];
int a_model [A_LEN];

function automatic void model_clear();
  foreach (w_model[i, k]) w_model[i][k] = 0;
  foreach (a_model[j]) a_model[j] = 0;
endfunction

// Weights below A_BASE, attention vector from A_BASE up
function automatic void model_write(input cfg_wr_t wr);
  int addr;
  addr = int'(wr.addr);
  if (addr < A_BASE) begin
    w_model[addr / NUM_FEAT_OUT][addr % NUM_FEAT_OUT] = int'($signed(wr.data));
  end else if (addr < A_BASE + A_LEN) begin
    a_model[addr - A_BASE] = int'($signed(wr.data));
  end
endfunction

// Wh[k] = sum of feat[i] * W[i][k], scores are a halves dotted with Wh
function automatic node_out_t model_predict(input node_in_t n);
  node_out_t r;
  int        wh [NUM_FEAT_OUT];
  int        src;
  int        dst;
  src = 0;
  dst = 0;
  for (int k = 0; k < NUM_FEAT_OUT; k++) begin
    wh[k] = 0;
    for (int i = 0; i < NUM_FEAT_IN; i++) begin
      wh[k] += int'($signed(n.feat[i])) * w_model[i][k];
    end
    src += a_model[k] * wh[k];
    dst += a_model[NUM_FEAT_OUT + k] * wh[k];
    r.wh[k] = WH_W'(wh[k]);
  end
  r.tag       = n.tag;
  r.score_src = SCORE_W'(src);
  r.score_dst = SCORE_W'(dst);
  return r;
endfunction

`endif

/* verification/tb_gat_proj.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_gat_proj;
  import gat_pkg::*;

  `include "gat_model.svh"

  localparam int N_NODES  = 1 + 200 + 200 + 30 + 30 + 50;
  localparam int N_WRITES = 4 * (NUM_FEAT_IN * NUM_FEAT_OUT + A_LEN);
  localparam int LIMIT    = 4 * (N_NODES + N_WRITES) + 200;

  logic      clk;
  logic      rst_n;
  logic      in_valid_i;
  logic      in_ready_o;
  node_in_t  in_node_i;
  logic      out_valid_o;
  logic      out_ready_i;
  node_out_t out_node_o;
  logic      cfg_we_i;
  cfg_wr_t   cfg_i;

  node_out_t exp_q [$];
  int        n_in;
  int        n_out;
  int        cycles;
  int        tag_next;
  logic      bp_mode;
  logic      ready_en;

  gat_proj_top u_gat_proj_top (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .in_node_i   (in_node_i),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_node_o  (out_node_o),
    .cfg_we_i    (cfg_we_i),
    .cfg_i       (cfg_i)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check_tag(input logic [TAG_W-1:0] got, input logic [TAG_W-1:0] want);
    if (got !== want) begin
      abort_run($sformatf("[ERROR] %0t ns tag got %0d expected %0d", $time, got, want));
    end
  endtask

  task automatic check_wh(input logic [TAG_W-1:0] tag,
                          input logic [NUM_FEAT_OUT-1:0][WH_W-1:0] got,
                          input logic [NUM_FEAT_OUT-1:0][WH_W-1:0] want);
    for (int k = 0; k < NUM_FEAT_OUT; k++) begin
      if (got[k] !== want[k]) begin
        abort_run($sformatf("[ERROR] %0t ns tag %0d wh[%0d] got %0d expected %0d",
                            $time, tag, k, $signed(got[k]), $signed(want[k])));
      end
    end
  endtask

  task automatic check_score(input string name, input logic [TAG_W-1:0] tag,
                             input logic [SCORE_W-1:0] got, input logic [SCORE_W-1:0] want);
    if (got !== want) begin
      abort_run($sformatf("[ERROR] %0t ns tag %0d %s got %0d expected %0d",
                          $time, tag, name, $signed(got), $signed(want)));
    end
  endtask

  // Mode 0 random, 1 random extreme, 2 all -128, 3 all 127
  function automatic logic [DATA_W-1:0] pick_value(input int mode);
    case (mode)
      0:       return DATA_W'($urandom);
      1:       return ($urandom_range(0, 1) == 1) ? 8'h7f : 8'h80;
      2:       return 8'h80;
      default: return 8'h7f;
    endcase
  endfunction

  function automatic node_in_t make_node(input int mode);
    node_in_t n;
    n.tag = TAG_W'(tag_next);
    tag_next++;
    for (int i = 0; i < NUM_FEAT_IN; i++) n.feat[i] = pick_value(mode);
    return n;
  endfunction

  // Called right after a falling edge
  task automatic send_node(input node_in_t n);
    logic took;
    took       = 1'b0;
    in_node_i  = n;
    in_valid_i = 1'b1;
    while (!took) begin
      @(posedge clk);
      took = in_ready_o;
      @(negedge clk);
    end
    in_valid_i = 1'b0;
  endtask

  task automatic load_config(input int mode);
    for (int addr = 0; addr < A_BASE + A_LEN; addr++) begin
      cfg_we_i   = 1'b1;
      cfg_i.addr = CFG_ADDR_W'(addr);
      cfg_i.data = pick_value(mode);
      model_write(cfg_i);
      @(negedge clk);
    end
    cfg_we_i = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) @(negedge clk);
  endtask

  // Sink held off until the reset state has been seen
  always @(negedge clk) begin
    if (!ready_en) begin
      out_ready_i <= 1'b0;
    end else if (bp_mode) begin
      out_ready_i <= 1'($urandom_range(0, 1));
    end else begin
      out_ready_i <= 1'b1;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > LIMIT) abort_run($sformatf("Timeout after %0d cycles", LIMIT));
  end

  // Expected values queued at input transfer and popped in order at output transfer
  always @(posedge clk) begin : scoreboard
    node_out_t want;
    if (rst_n) begin
      if (in_valid_i && in_ready_o) begin
        exp_q.push_back(model_predict(in_node_i));
        n_in++;
      end
      if (out_valid_o && out_ready_i) begin
        if (exp_q.size() == 0) abort_run("Output transfer with no node pending");
        want = exp_q.pop_front();
        check_tag(out_node_o.tag, want.tag);
        check_wh(want.tag, out_node_o.wh, want.wh);
        check_score("score_src", want.tag, out_node_o.score_src, want.score_src);
        check_score("score_dst", want.tag, out_node_o.score_dst, want.score_dst);
        n_out++;
      end
    end
  end

  initial begin
    void'($urandom(32'hf7dc_a327));
    rst_n       = 1'b0;
    in_valid_i  = 1'b0;
    in_node_i   = '0;
    out_ready_i = 1'b0;
    cfg_we_i    = 1'b0;
    cfg_i       = '0;
    n_in        = 0;
    n_out       = 0;
    cycles      = 0;
    tag_next    = 0;
    bp_mode     = 1'b0;
    ready_en    = 1'b0;
    model_clear();
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    if (out_valid_o !== 1'b0 || in_ready_o !== 1'b1) begin
      abort_run($sformatf("[ERROR] %0t ns after reset out_valid_o %b in_ready_o %b",
                          $time, out_valid_o, in_ready_o));
    end
    @(posedge clk);
    ready_en = 1'b1;
    @(negedge clk);
    // Unconfigured weights give zero results
    send_node(make_node(0));
    wait_drain();
    load_config(0);
    repeat (200) send_node(make_node(0));
    wait_drain();
    bp_mode = 1'b1;
    repeat (200) begin
      if ($urandom_range(0, 3) == 0) @(negedge clk);
      send_node(make_node(0));
    end
    wait_drain();
    bp_mode = 1'b0;
    // Extreme values with the largest magnitudes first
    load_config(2);
    send_node(make_node(2));
    send_node(make_node(3));
    repeat (28) send_node(make_node(1));
    wait_drain();
    load_config(1);
    repeat (30) send_node(make_node(1));
    wait_drain();
    load_config(0);
    repeat (50) send_node(make_node(0));
    wait_drain();
    if (n_out != n_in || n_in != N_NODES) begin
      abort_run($sformatf("[ERROR] %0t ns node count %0d in and %0d out expected %0d",
                          $time, n_in, n_out, N_NODES));
    end else begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire
